//--- list.f
verilog/rvPkg.sv
verilog/ctrlIf.sv
verilog/predIf.sv
verilog/branchPredictor.sv
verilog/controller.sv
verilog/datapath.sv
verilog/pipelineCore.sv
test/memModel.sv
test/coreTb.sv

//--- run.sh
#!/bin/sh
# Builds the core testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -j 0 \
    --top-module coreTb -Mdir obj_dir -o simCore -f list.f

./obj_dir/simCore | tee sim.log

if grep -q "Verification passed" sim.log; then
    exit 0
fi
exit 1

//--- test/coreTb.sv
`timescale 1ns/1ns
`default_nettype none

module coreTb;
    import rvPkg::*;

    localparam word_t resetPc    = 32'h80;
    localparam word_t markerAddr = 32'h3FC;
    localparam int longestDyn    = 45;  // Dynamic instructions of the branch loop up to the marker
    // Every instruction redirected plus pipeline fill
    localparam int timeoutCycles = 3 * longestDyn + 8;

    logic  clk = 1'b0;
    logic  reset = 1'b1;
    wire word_t imemAddr, imemData, dmemAddr, dmemWData, dmemRData;
    wire   dmemWe;
    int    runCycles = 0;
    int    errorCount = 0;
    int    testCount = 0;
    int    failedTests = 0;
    int    testErrStart = 0;
    word_t prog[$];
    word_t expAddr[$];
    word_t expData[$];

    always #50 clk = ~clk;

    pipelineCore #(
        .resetPc  (resetPc),
        .histBits (5),
        .btbBits  (5)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .imemAddr_o  (imemAddr),
        .imemData_i  (imemData),
        .dmemAddr_o  (dmemAddr),
        .dmemWData_o (dmemWData),
        .dmemWe_o    (dmemWe),
        .dmemRData_i (dmemRData)
    );

    memModel mem0 (
        .clk         (clk),
        .imemAddr_i  (imemAddr),
        .imemData_o  (imemData),
        .dmemAddr_i  (dmemAddr),
        .dmemWData_i (dmemWData),
        .dmemWe_i    (dmemWe),
        .dmemRData_o (dmemRData)
    );

    // Cycles since reset
    always @(posedge clk) begin
        if (reset) begin
            runCycles <= 0;
        end else if (runCycles >= timeoutCycles) begin
            $display("Timeout: no marker store within %0d cycles", timeoutCycles);
            $display("Verification failed");
            $finish;
        end else begin
            runCycles <= runCycles + 1;
        end
    end

    // Instruction formats
    function automatic word_t rType(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opOp};
    endfunction

    function automatic word_t iType(int imm, int rs1, logic [2:0] f3, int rd, opcode_t op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic word_t sType(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opStore};
    endfunction

    function automatic word_t bType(int imm, int rs2, int rs1);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic word_t jType(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opJal};
    endfunction

    function automatic word_t uType(int imm20, int rd);
        return {imm20[19:0], rd[4:0], opLui};
    endfunction

    function automatic word_t addi(int rd, int rs1, int imm);
        return iType(imm, rs1, 3'b000, rd, opOpImm);
    endfunction

    task automatic checkValue(string what, word_t got, word_t exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errorCount++;
        end
    endtask

    task automatic expectStore(word_t addr, word_t data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic startTest();
        prog.delete();
        expAddr.delete();
        expData.delete();
        testErrStart = errorCount;
    endtask

    task automatic reportTest(string name);
        testCount++;
        if (errorCount == testErrStart) begin
            $display("Test %s: ok", name);
        end else begin
            failedTests++;
            $display("Test %s: %0d errors", name, errorCount - testErrStart);
        end
    endtask

    // Two cycles of reset and a look at the first fetch address
    task automatic applyReset();
        @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        checkValue("dmemWe_o", {31'b0, dmemWe}, '0);
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkValue("imemAddr_o", imemAddr, resetPc);
    endtask

    task automatic checkStores();
        assert (mem0.logAddr.size() == expAddr.size() + 1) else begin
            $display("Wrong store count at %0t ns: %0d logged, %0d expected plus the marker",
                     $time, mem0.logAddr.size(), expAddr.size());
            errorCount++;
        end
        for (int i = 0; i < expAddr.size() && i < mem0.logAddr.size(); i++) begin
            checkValue($sformatf("dmemAddr_o of store %0d", i), mem0.logAddr[i], expAddr[i]);
            checkValue($sformatf("dmemWData_o of store %0d", i), mem0.logData[i], expData[i]);
        end
    endtask

    // Appends the marker store, resets the core, loads the ROM and runs until the marker
    task automatic runProgram();
        bit markerSeen;
        prog.push_back(sType(markerAddr, 0, 0));
        applyReset();
        for (int i = 0; i < 256; i++) begin
            mem0.rom[i] = 32'h00000013;
        end
        for (int i = 0; i < prog.size(); i++) begin
            mem0.rom[resetPc[9:2] + i] = prog[i];
        end
        mem0.clearLog();
        markerSeen = 1'b0;
        while (!markerSeen) begin
            @(negedge clk);
            markerSeen = dmemWe && dmemAddr == markerAddr;
        end
        @(negedge clk);  // Marker now in the log
        checkStores();
    endtask

    task automatic testReset();
        startTest();
        runProgram();
        reportTest("reset");
    endtask

    task automatic testArith();
        word_t r [11];
        startTest();
        r[1]  = 13;
        r[2]  = r[1] - 32'd5;
        r[3]  = r[1] + r[2];
        r[4]  = r[2] - r[3];
        r[5]  = r[3] & r[4];
        r[6]  = r[5] | r[1];
        r[7]  = ($signed(r[4]) < $signed(r[1])) ? 32'd1 : 32'd0;
        r[8]  = r[6] & 32'd12;
        r[9]  = r[4] | 32'd3;
        r[10] = ($signed(r[4]) < -12) ? 32'd1 : 32'd0;
        prog.push_back(addi(1, 0, 13));
        prog.push_back(addi(2, 1, -5));
        prog.push_back(rType(7'h00, 2, 1, 3'b000, 3));  // add
        prog.push_back(rType(7'h20, 3, 2, 3'b000, 4));  // sub
        prog.push_back(rType(7'h00, 4, 3, 3'b111, 5));  // and
        prog.push_back(rType(7'h00, 1, 5, 3'b110, 6));  // or
        prog.push_back(rType(7'h00, 1, 4, 3'b010, 7));  // slt
        prog.push_back(iType(12, 6, 3'b111, 8, opOpImm));
        prog.push_back(iType(3, 4, 3'b110, 9, opOpImm));
        prog.push_back(iType(-12, 4, 3'b010, 10, opOpImm));
        for (int k = 1; k <= 10; k++) begin
            prog.push_back(sType(32'h100 + 4 * k, k, 0));
            expectStore(32'h100 + 4 * k, r[k]);
        end
        runProgram();
        reportTest("arithmetic and forwarding");
    endtask

    task automatic testLoadUse();
        startTest();
        prog.push_back(addi(1, 0, 77));
        prog.push_back(sType(32'h40, 1, 0));
        prog.push_back(iType(32'h40, 0, 3'b010, 2, opLoad));
        prog.push_back(rType(7'h00, 1, 2, 3'b000, 3));  // Uses the load at once
        prog.push_back(sType(32'h44, 3, 0));
        expectStore(32'h40, 77);
        expectStore(32'h44, 77 + 77);
        runProgram();
        reportTest("load-use");
    endtask

    task automatic testBranchLoop();
        word_t sum;
        startTest();
        sum = '0;
        for (int i = 1; i <= 10; i++) begin
            sum = sum + i;
        end
        prog.push_back(addi(1, 0, 0));
        prog.push_back(addi(2, 0, 0));
        prog.push_back(addi(5, 0, 10));
        prog.push_back(addi(1, 1, 1));                  // Loop head
        prog.push_back(rType(7'h00, 1, 2, 3'b000, 2));
        prog.push_back(bType(8, 5, 1));                 // Exit after ten passes
        prog.push_back(bType(-12, 0, 0));               // Back to the head
        prog.push_back(bType(8, 0, 2));                 // Never taken
        prog.push_back(sType(32'h80, 2, 0));
        expectStore(32'h80, sum);
        runProgram();
        reportTest("branch loop");
    endtask

    task automatic testJalLui();
        startTest();
        prog.push_back(jType(12, 1));        // Over the next two
        prog.push_back(sType(32'h90, 5, 0));
        prog.push_back(sType(32'h94, 5, 0));
        prog.push_back(sType(32'h98, 1, 0));
        prog.push_back(uType(20'hABCDE, 6));
        prog.push_back(sType(32'h9C, 6, 0));
        expectStore(32'h98, resetPc + 32'd4);
        expectStore(32'h9C, 32'hABCDE << 12);
        runProgram();
        reportTest("jal and lui");
    endtask

    task automatic testRandomImm();
        int    imm;
        word_t sum;
        startTest();
        sum = '0;
        prog.push_back(addi(1, 0, 0));
        for (int k = 0; k < 8; k++) begin
            imm = int'($urandom_range(4095)) - 2048;  // Signed 12-bit range
            prog.push_back(addi(1, 1, imm));
            sum = sum + imm;
        end
        prog.push_back(sType(32'hA0, 1, 0));
        expectStore(32'hA0, sum);
        runProgram();
        reportTest("random immediates");
    endtask

    initial begin
        void'($urandom(79));
        testReset();
        testArith();
        testLoadUse();
        testBranchLoop();
        testJalLui();
        testRandomImm();
        $display("Summary: %0d tests, %0d failed, %0d errors", testCount, failedTests,
                 errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/memModel.sv
`timescale 1ns/1ns
`default_nettype none

module memModel (
    input  wire               clk,
    input  wire rvPkg::word_t imemAddr_i,
    output wire rvPkg::word_t imemData_o,
    input  wire rvPkg::word_t dmemAddr_i,
    input  wire rvPkg::word_t dmemWData_i,
    input  wire               dmemWe_i,
    output wire rvPkg::word_t dmemRData_o
);
    import rvPkg::*;

    localparam word_t nop = 32'h00000013;  // addi x0, x0, 0

    word_t rom [256];  // 1 KB each, word addressed
    word_t ram [256];
    word_t logAddr [$];
    word_t logData [$];

    initial begin
        for (int i = 0; i < 256; i++) begin
            rom[i] = nop;
            ram[i] = 32'hD0000000 | (i << 2);  // Byte address shows through
        end
    end

    // Combinational reads
    assign imemData_o  = rom[imemAddr_i[9:2]];
    assign dmemRData_o = ram[dmemAddr_i[9:2]];

    // Stores land on the clock edge and are logged in order
    always @(posedge clk) begin
        if (dmemWe_i) begin
            ram[dmemAddr_i[9:2]] = dmemWData_i;
            logAddr.push_back(dmemAddr_i);
            logData.push_back(dmemWData_i);
        end
    end

    task automatic clearLog();
        logAddr.delete();
        logData.delete();
    endtask

endmodule

`default_nettype wire

//--- verilog/branchPredictor.sv
`timescale 1ns/1ns
`default_nettype none

module branchPredictor #(
    parameter int histBits = 5,
    parameter int btbBits  = 5
) (
    input  wire      clk,
    input  wire      reset,
    predIf.predictor pred
);
    import rvPkg::*;

    localparam int phtSize = 1 << histBits;
    localparam int btbSize = 1 << btbBits;

    logic [1:0]          pht [phtSize];  // Two-bit saturating counters
    logic [histBits-1:0] ghr;
    logic                btbValid [btbSize];
    word_t               btbTarget [btbSize];
    logic [btbBits-1:0]  btbIdxF;
    logic [btbBits-1:0]  btbIdxU;
    logic [1:0]          ctrUpd;

    // Gshare index, word-aligned PC bits folded with the history
    assign pred.histIdxF = pred.pcF[histBits+1:2] ^ ghr;
    assign btbIdxF = pred.pcF[btbBits+1:2];
    assign btbIdxU = pred.updPc[btbBits+1:2];

    // Taken needs a known target and a counter in the upper half
    assign pred.predTakenF  = btbValid[btbIdxF] && pht[pred.histIdxF][1];
    assign pred.predTargetF = btbTarget[btbIdxF];

    assign ctrUpd = pht[pred.updIdx];

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
            for (int i = 0; i < phtSize; i++) begin
                pht[i] <= 2'b00;
            end
            for (int i = 0; i < btbSize; i++) begin
                btbValid[i]  <= 1'b0;
                btbTarget[i] <= '0;
            end
        end else if (pred.updEn) begin
            if (pred.updTaken && ctrUpd != 2'b11) begin
                pht[pred.updIdx] <= ctrUpd + 2'd1;
            end else if (!pred.updTaken && ctrUpd != 2'b00) begin
                pht[pred.updIdx] <= ctrUpd - 2'd1;
            end
            // History tracks conditional outcomes only
            if (pred.updIsBranch) begin
                ghr <= {ghr[histBits-2:0], pred.updTaken};
            end
            if (pred.updTaken) begin
                btbValid[btbIdxU]  <= 1'b1;
                btbTarget[btbIdxU] <= pred.updTarget;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/controller.sv
`timescale 1ns/1ns
`default_nettype none

module controller (
    input  wire       clk,
    input  wire       reset,
    ctrlIf.controller ctrl
);
    import rvPkg::*;

    logic     regWriteD, memWriteD, aluSrcD;
    aluCtrl_t aluCtrlD;
    logic     regWriteE, memWriteE;
    logic     regWriteM;
    logic     lwStall;

    // Main decoder
    always_comb begin
        regWriteD    = 1'b0;
        memWriteD    = 1'b0;
        aluSrcD      = 1'b1;  // Immediate operand unless noted
        ctrl.immSrcD = immI;
        case (ctrl.opD)
            opLoad: regWriteD = 1'b1;
            opStore: begin
                memWriteD    = 1'b1;
                ctrl.immSrcD = immS;
            end
            opOp: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b0;
            end
            opOpImm: regWriteD = 1'b1;
            opBranch: begin
                aluSrcD      = 1'b0;
                ctrl.immSrcD = immB;
            end
            opJal: begin
                regWriteD    = 1'b1;
                ctrl.immSrcD = immJ;
            end
            opLui: begin
                regWriteD    = 1'b1;
                ctrl.immSrcD = immU;
            end
            default: regWriteD = 1'b0;  // Bubble or unsupported
        endcase
    end

    // ALU decoder, loads and stores only need the address add
    always_comb begin
        aluCtrlD = aluAdd;
        if (ctrl.opD == opOp || ctrl.opD == opOpImm) begin
            case (ctrl.funct3D)
                3'b000:  aluCtrlD = (ctrl.opD == opOp && ctrl.funct7b5D) ? aluSub : aluAdd;
                3'b010:  aluCtrlD = aluSlt;
                3'b110:  aluCtrlD = aluOr;
                3'b111:  aluCtrlD = aluAnd;
                default: aluCtrlD = aluAdd;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset || ctrl.flushE) begin
            regWriteE     <= 1'b0;
            memWriteE     <= 1'b0;
            ctrl.aluSrcE  <= 1'b0;
            ctrl.aluCtrlE <= aluAdd;
        end else begin
            regWriteE     <= regWriteD;
            memWriteE     <= memWriteD;
            ctrl.aluSrcE  <= aluSrcD;
            ctrl.aluCtrlE <= aluCtrlD;
        end
    end

    // Memory and writeback controls, result class comes from execute
    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteM       <= 1'b0;
            ctrl.memWriteM  <= 1'b0;
            ctrl.resultSrcM <= resAlu;
            ctrl.regWriteW  <= 1'b0;
            ctrl.resultSrcW <= resAlu;
        end else begin
            regWriteM       <= regWriteE;
            ctrl.memWriteM  <= memWriteE;
            ctrl.resultSrcM <= ctrl.resultSrcE;
            ctrl.regWriteW  <= regWriteM;
            ctrl.resultSrcW <= ctrl.resultSrcM;
        end
    end

    // Newest producer wins, x0 never forwards
    function automatic forward_t fwdSel(regAddr_t rs, regAddr_t rdM, logic weM,
                                        regAddr_t rdW, logic weW);
        if (rs != '0 && weM && rs == rdM) begin
            return fwdMem;
        end else if (rs != '0 && weW && rs == rdW) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    always_comb begin
        ctrl.forwardAE = fwdSel(ctrl.rs1E, ctrl.rdM, regWriteM, ctrl.rdW, ctrl.regWriteW);
        ctrl.forwardBE = fwdSel(ctrl.rs2E, ctrl.rdM, regWriteM, ctrl.rdW, ctrl.regWriteW);
    end

    assign lwStall = (ctrl.resultSrcE == resMem) && (ctrl.rdE != '0) &&
                     (ctrl.rdE == ctrl.rs1D || ctrl.rdE == ctrl.rs2D);

    assign ctrl.stallF = lwStall;
    assign ctrl.stallD = lwStall;
    assign ctrl.flushD = ctrl.redirectE;
    assign ctrl.flushE = lwStall || ctrl.redirectE;  // Bubble or wrong path

endmodule

`default_nettype wire

//--- verilog/ctrlIf.sv
`timescale 1ns/1ns
`default_nettype none

interface ctrlIf;
    import rvPkg::*;

    // Instruction fields and stage state from the datapath
    opcode_t    opD;
    logic [2:0] funct3D;
    logic       funct7b5D;
    regAddr_t   rs1D, rs2D, rs1E, rs2E;
    regAddr_t   rdE, rdM, rdW;
    resultSrc_t resultSrcE;  // Load detection in execute
    logic       redirectE;

    // Per-stage controls from the controller
    immSrc_t    immSrcD;
    aluCtrl_t   aluCtrlE;
    logic       aluSrcE;
    forward_t   forwardAE, forwardBE;
    logic       memWriteM, regWriteW;
    resultSrc_t resultSrcM, resultSrcW;
    logic       stallF, stallD, flushD, flushE;

    modport controller (
        input  opD, funct3D, funct7b5D, rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
        input  resultSrcE, redirectE,
        output immSrcD, aluCtrlE, aluSrcE, forwardAE, forwardBE,
        output memWriteM, resultSrcM, resultSrcW, regWriteW,
        output stallF, stallD, flushD, flushE
    );

    modport datapath (
        output opD, funct3D, funct7b5D, rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
        output resultSrcE, redirectE,
        input  immSrcD, aluCtrlE, aluSrcE, forwardAE, forwardBE,
        input  memWriteM, resultSrcM, resultSrcW, regWriteW,
        input  stallF, stallD, flushD, flushE
    );

endinterface

`default_nettype wire

//--- verilog/datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath #(
    parameter rvPkg::word_t resetPc  = '0,
    parameter int           histBits = 5
) (
    input  wire               clk,
    input  wire               reset,
    ctrlIf.datapath           ctrl,
    predIf.datapath           pred,
    output wire rvPkg::word_t imemAddr_o,
    input  wire rvPkg::word_t imemData_i,
    output wire rvPkg::word_t dmemAddr_o,
    output wire rvPkg::word_t dmemWData_o,
    output wire               dmemWe_o,
    input  wire rvPkg::word_t dmemRData_i
);
    import rvPkg::*;

    word_t               pcF, pcPlus4F, pcNextF;
    word_t               instrD, pcD, predTargetD, immD, rd1D, rd2D;
    logic                predTakenD;
    logic [histBits-1:0] histIdxD;
    regAddr_t            rdD;
    word_t               regFile [32];
    word_t               pcE, immE, rd1E, rd2E, predTargetE;
    opcode_t             opE;
    logic                predTakenE, takenE;
    logic [histBits-1:0] histIdxE;
    word_t               srcAE, srcBE, writeDataE, aluResultE;
    word_t               pcPlus4E, targetE, actualNextE, predNextE;
    word_t               aluResultM, writeDataM, pcPlus4M, immM, fwdDataM;
    word_t               aluResultW, readDataW, pcPlus4W, immW, resultW;

    function automatic word_t pickOperand(forward_t sel, word_t regVal, word_t memVal,
                                          word_t wbVal);
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    function automatic word_t pickResult(resultSrc_t sel, word_t alu, word_t mem,
                                         word_t pc4, word_t imm);
        case (sel)
            resMem:     return mem;
            resPcPlus4: return pc4;
            resImm:     return imm;
            default:    return alu;
        endcase
    endfunction

    // Fetch, execute redirect overrides the prediction
    assign pred.pcF    = pcF;
    assign imemAddr_o  = pcF;
    assign pcPlus4F    = pcF + 32'd4;
    assign pcNextF     = ctrl.redirectE ? actualNextE :
                         pred.predTakenF ? pred.predTargetF : pcPlus4F;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF <= resetPc;
        end else if (!ctrl.stallF) begin
            pcF <= pcNextF;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || ctrl.flushD) begin
            instrD      <= '0;
            pcD         <= '0;
            predTakenD  <= 1'b0;
            predTargetD <= '0;
            histIdxD    <= '0;
        end else if (!ctrl.stallD) begin
            instrD      <= imemData_i;
            pcD         <= pcF;
            predTakenD  <= pred.predTakenF;
            predTargetD <= pred.predTargetF;
            histIdxD    <= pred.histIdxF;
        end
    end

    // Decode
    assign ctrl.opD       = instrD[6:0];
    assign ctrl.funct3D   = instrD[14:12];
    assign ctrl.funct7b5D = instrD[30];
    assign ctrl.rs1D      = instrD[19:15];
    assign ctrl.rs2D      = instrD[24:20];
    assign rdD            = instrD[11:7];

    // Falling-edge write makes the value visible to decode in the same cycle
    always_ff @(negedge clk) begin
        if (ctrl.regWriteW && ctrl.rdW != '0) begin
            regFile[ctrl.rdW] <= resultW;
        end
    end

    assign rd1D = (ctrl.rs1D == '0) ? '0 : regFile[ctrl.rs1D];
    assign rd2D = (ctrl.rs2D == '0) ? '0 : regFile[ctrl.rs2D];

    always_comb begin
        case (ctrl.immSrcD)
            immS:    immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            immB:    immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            immJ:    immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            immU:    immD = {instrD[31:12], 12'b0};
            default: immD = {{20{instrD[31]}}, instrD[31:20]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || ctrl.flushE) begin
            pcE         <= '0;
            immE        <= '0;
            rd1E        <= '0;
            rd2E        <= '0;
            opE         <= '0;
            predTakenE  <= 1'b0;
            predTargetE <= '0;
            histIdxE    <= '0;
            ctrl.rs1E   <= '0;
            ctrl.rs2E   <= '0;
            ctrl.rdE    <= '0;
        end else begin
            pcE         <= pcD;
            immE        <= immD;
            rd1E        <= rd1D;
            rd2E        <= rd2D;
            opE         <= ctrl.opD;
            predTakenE  <= predTakenD;
            predTargetE <= predTargetD;
            histIdxE    <= histIdxD;
            ctrl.rs1E   <= ctrl.rs1D;
            ctrl.rs2E   <= ctrl.rs2D;
            ctrl.rdE    <= rdD;
        end
    end

    // Execute
    assign srcAE      = pickOperand(ctrl.forwardAE, rd1E, fwdDataM, resultW);
    assign writeDataE = pickOperand(ctrl.forwardBE, rd2E, fwdDataM, resultW);
    assign srcBE      = ctrl.aluSrcE ? immE : writeDataE;

    always_comb begin
        case (ctrl.aluCtrlE)
            aluSub:  aluResultE = srcAE - srcBE;
            aluAnd:  aluResultE = srcAE & srcBE;
            aluOr:   aluResultE = srcAE | srcBE;
            aluSlt:  aluResultE = {31'b0, $signed(srcAE) < $signed(srcBE)};
            default: aluResultE = srcAE + srcBE;
        endcase
    end

    always_comb begin
        case (opE)
            opLoad:  ctrl.resultSrcE = resMem;
            opJal:   ctrl.resultSrcE = resPcPlus4;
            opLui:   ctrl.resultSrcE = resImm;
            default: ctrl.resultSrcE = resAlu;
        endcase
    end

    // Actual outcome against the next PC fetch assumed
    assign pcPlus4E    = pcE + 32'd4;
    assign targetE     = pcE + immE;
    assign takenE      = (opE == opJal) || (opE == opBranch && srcAE == writeDataE);
    assign actualNextE = takenE ? targetE : pcPlus4E;
    assign predNextE   = predTakenE ? predTargetE : pcPlus4E;
    assign ctrl.redirectE = (opE != '0) && (predNextE != actualNextE);  // Bubbles have opcode 0

    assign pred.updEn       = (opE == opBranch) || (opE == opJal);
    assign pred.updIsBranch = (opE == opBranch);
    assign pred.updTaken    = takenE;
    assign pred.updPc       = pcE;
    assign pred.updTarget   = targetE;
    assign pred.updIdx      = histIdxE;

    always_ff @(posedge clk) begin
        if (reset) begin
            aluResultM <= '0;
            writeDataM <= '0;
            pcPlus4M   <= '0;
            immM       <= '0;
            ctrl.rdM   <= '0;
        end else begin
            aluResultM <= aluResultE;
            writeDataM <= writeDataE;
            pcPlus4M   <= pcPlus4E;
            immM       <= immE;
            ctrl.rdM   <= ctrl.rdE;
        end
    end

    // Memory stage, a load here is never forwarded thanks to the stall
    assign fwdDataM    = pickResult(ctrl.resultSrcM, aluResultM, aluResultM, pcPlus4M, immM);
    assign dmemAddr_o  = aluResultM;
    assign dmemWData_o = writeDataM;
    assign dmemWe_o    = ctrl.memWriteM;

    always_ff @(posedge clk) begin
        if (reset) begin
            aluResultW <= '0;
            readDataW  <= '0;
            pcPlus4W   <= '0;
            immW       <= '0;
            ctrl.rdW   <= '0;
        end else begin
            aluResultW <= aluResultM;
            readDataW  <= dmemRData_i;
            pcPlus4W   <= pcPlus4M;
            immW       <= immM;
            ctrl.rdW   <= ctrl.rdM;
        end
    end

    assign resultW = pickResult(ctrl.resultSrcW, aluResultW, readDataW, pcPlus4W, immW);

endmodule

`default_nettype wire

//--- verilog/pipelineCore.sv
`timescale 1ns/1ns
`default_nettype none

module pipelineCore #(
    parameter rvPkg::word_t resetPc  = '0,
    parameter int           histBits = 5,
    parameter int           btbBits  = 5
) (
    input  wire               clk,
    input  wire               reset,
    output wire rvPkg::word_t imemAddr_o,
    input  wire rvPkg::word_t imemData_i,
    output wire rvPkg::word_t dmemAddr_o,
    output wire rvPkg::word_t dmemWData_o,
    output wire               dmemWe_o,
    input  wire rvPkg::word_t dmemRData_i
);

    ctrlIf ctrl0 ();
    predIf #(.histBits(histBits)) pred0 ();

    controller ctrlUnit0 (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl0.controller)
    );

    datapath #(
        .resetPc  (resetPc),
        .histBits (histBits)
    ) dp0 (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl0.datapath),
        .pred        (pred0.datapath),
        .imemAddr_o  (imemAddr_o),
        .imemData_i  (imemData_i),
        .dmemAddr_o  (dmemAddr_o),
        .dmemWData_o (dmemWData_o),
        .dmemWe_o    (dmemWe_o),
        .dmemRData_i (dmemRData_i)
    );

    branchPredictor #(
        .histBits (histBits),
        .btbBits  (btbBits)
    ) bp0 (
        .clk   (clk),
        .reset (reset),
        .pred  (pred0.predictor)
    );

endmodule

`default_nettype wire

//--- verilog/predIf.sv
`timescale 1ns/1ns
`default_nettype none

interface predIf #(
    parameter int histBits = 5
);
    import rvPkg::*;

    // Fetch side lookup
    word_t               pcF;
    logic                predTakenF;
    word_t               predTargetF;
    logic [histBits-1:0] histIdxF;

    // Training from execute
    logic                updEn, updIsBranch, updTaken;
    word_t               updPc, updTarget;
    logic [histBits-1:0] updIdx;

    modport datapath (
        output pcF, updEn, updIsBranch, updTaken, updPc, updTarget, updIdx,
        input  predTakenF, predTargetF, histIdxF
    );

    modport predictor (
        input  pcF, updEn, updIsBranch, updTaken, updPc, updTarget, updIdx,
        output predTakenF, predTargetF, histIdxF
    );

endinterface

`default_nettype wire

//--- verilog/rvPkg.sv
`default_nettype none

package rvPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  immSrc_t;
    typedef logic [2:0]  aluCtrl_t;
    typedef logic [1:0]  resultSrc_t;
    typedef logic [1:0]  forward_t;

    // Major opcodes of the supported RV32I subset
    localparam opcode_t opLoad   = 7'b0000011;
    localparam opcode_t opStore  = 7'b0100011;
    localparam opcode_t opOp     = 7'b0110011;
    localparam opcode_t opOpImm  = 7'b0010011;
    localparam opcode_t opBranch = 7'b1100011;
    localparam opcode_t opJal    = 7'b1101111;
    localparam opcode_t opLui    = 7'b0110111;

    // Immediate formats
    localparam immSrc_t immI = 3'd0;
    localparam immSrc_t immS = 3'd1;
    localparam immSrc_t immB = 3'd2;
    localparam immSrc_t immJ = 3'd3;
    localparam immSrc_t immU = 3'd4;

    localparam aluCtrl_t aluAdd = 3'd0;
    localparam aluCtrl_t aluSub = 3'd1;
    localparam aluCtrl_t aluAnd = 3'd2;
    localparam aluCtrl_t aluOr  = 3'd3;
    localparam aluCtrl_t aluSlt = 3'd4;

    // Writeback source
    localparam resultSrc_t resAlu     = 2'd0;
    localparam resultSrc_t resMem     = 2'd1;
    localparam resultSrc_t resPcPlus4 = 2'd2;
    localparam resultSrc_t resImm     = 2'd3;

    // Execute operand source
    localparam forward_t fwdReg = 2'd0;
    localparam forward_t fwdWb  = 2'd1;
    localparam forward_t fwdMem = 2'd2;

endpackage

`default_nettype wire
